//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_sys_stream_bridge
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/card_info_regs.sv
// -------------------------------------------------------------------------
// Card information registers
// Read-only identification words the host uses to find out what card
// and framework it is talking to
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module card_info_regs (
    input  logic                            s_clk,
    input  logic                            s_rst,

    input  logic [sysbus_pkg::addr_w-1:0]   bus_addr,
    input  logic                            bus_rd,
    input  logic [7:0]                      user_pb_width,

    output logic [sysbus_pkg::reg_w-1:0]    rd_data
);

    logic [sysbus_pkg::reg_w-1:0] bus_width_word;

    // User bus width sits in the low byte
    assign bus_width_word = {{(sysbus_pkg::reg_w-8){1'b0}}, user_pb_width};

    // ---------------------------------------------------------------------
    // Registered read mux
    // ---------------------------------------------------------------------
    // Output drops back to zero on every cycle without a hit so the
    // top level can OR this block with the others
    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            rd_data <= '0;
        end else if (bus_rd) begin
            case (bus_addr)
                sysbus_pkg::addr_magic:     rd_data <= sysbus_pkg::card_magic;
                sysbus_pkg::addr_version:   rd_data <= sysbus_pkg::card_version;
                sysbus_pkg::addr_bus_width: rd_data <= bus_width_word;
                default:                    rd_data <= '0;  // Not ours
            endcase
        end else begin
            rd_data <= '0;
        end
    end

endmodule

//--- rtl/cmd_decoder.sv
// -------------------------------------------------------------------------
// Command decoder
// Picks register commands off the inbound stream by id and turns each
// one into a single-cycle read or write strobe on the register bus
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module cmd_decoder #(
    parameter int data_w    = 128,
    parameter int stream_id = 126
) (
    input  logic                            s_clk,
    input  logic                            s_rst,

    input  logic                            s_in_valid,
    input  logic [sysbus_pkg::id_w-1:0]     s_in_id,
    input  logic [data_w-1:0]               s_in_data,

    output logic [sysbus_pkg::addr_w-1:0]   bus_addr,
    output logic [sysbus_pkg::reg_w-1:0]    bus_wdata,
    output logic                            bus_wr,
    output logic                            bus_rd,
    output logic                            rd_pending
);

    localparam logic [sysbus_pkg::id_w-1:0] own_id = stream_id[sysbus_pkg::id_w-1:0];

    logic cmd_hit;
    logic cmd_is_write;

    assign cmd_hit      = s_in_valid && (s_in_id == own_id);   // Other streams pass by
    assign cmd_is_write = s_in_data[sysbus_pkg::cmd_write_bit];

    // Address and write data only move on an accepted command
    always_ff @(posedge s_clk) begin
        if (cmd_hit) begin
            bus_addr  <= s_in_data[sysbus_pkg::cmd_addr_lsb +: sysbus_pkg::addr_w];
            bus_wdata <= s_in_data[sysbus_pkg::cmd_wdata_lsb +: sysbus_pkg::reg_w];
        end
    end

    // Strobes last one cycle, rd_pending marks the read data cycle
    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            bus_wr     <= 1'b0;
            bus_rd     <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            bus_wr     <= cmd_hit && cmd_is_write;
            bus_rd     <= cmd_hit && !cmd_is_write;
            rd_pending <= bus_rd;                       // Blocks answer one cycle later
        end
    end

endmodule

//--- rtl/resp_queue.sv
// -------------------------------------------------------------------------
// Response queue
// Holds register read results until the host pulls them off the
// outbound stream, and reports the fill level on a poll of its id
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module resp_queue #(
    parameter int data_w      = 128,
    parameter int stream_id   = 126,
    parameter int queue_depth = 8
) (
    input  logic                            s_clk,
    input  logic                            s_rst,

    input  logic                            rd_pending,
    input  logic [sysbus_pkg::reg_w-1:0]    bus_rdata,

    input  logic                            s_out_en,
    input  logic [sysbus_pkg::id_w-1:0]     s_out_id,
    output logic [data_w-1:0]               s_out_data,
    output logic                            s_out_ow_dvld,

    input  logic [sysbus_pkg::id_w-1:0]     s_poll_id,
    output logic [sysbus_pkg::reg_w-1:0]    s_poll_seq
);

    localparam int                          ptr_w      = $clog2(queue_depth);
    localparam logic [ptr_w:0]              full_count = queue_depth[ptr_w:0];
    localparam logic [sysbus_pkg::id_w-1:0] own_id     = stream_id[sysbus_pkg::id_w-1:0];

    logic [sysbus_pkg::reg_w-1:0] mem [queue_depth];

    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w:0]     count;                  // One bit wider to tell full from empty

    logic push;
    logic pop;

    // Result is dropped when full, host is expected to poll first
    assign push = rd_pending && (count != full_count);
    assign pop  = s_out_en && (s_out_id == own_id) && (count != '0);

    // ---------------------------------------------------------------------
    // Storage
    // ---------------------------------------------------------------------
    always_ff @(posedge s_clk) begin
        if (push)
            mem[wr_ptr] <= bus_rdata;
    end

    // ---------------------------------------------------------------------
    // Pointers and fill level
    // ---------------------------------------------------------------------
    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;        // Power-of-two depth, wraps by itself
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // Outbound stream and poll
    // ---------------------------------------------------------------------
    always_ff @(posedge s_clk) begin
        if (pop)
            s_out_data <= {{(data_w-sysbus_pkg::reg_w){1'b0}}, mem[rd_ptr]};
    end

    // Poll answer stays zero for other ids so streams can be OR-merged
    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            s_out_ow_dvld <= 1'b0;
            s_poll_seq    <= '0;
        end else begin
            s_out_ow_dvld <= pop;
            if (s_poll_id == own_id)
                s_poll_seq <= {{(sysbus_pkg::reg_w-ptr_w-1){1'b0}}, count};
            else
                s_poll_seq <= '0;
        end
    end

endmodule

//--- rtl/sys_stream_bridge.sv
// -------------------------------------------------------------------------
// System stream bridge
// Carries framework register traffic over the reserved system stream.
// Decode, register access and response queue form a three-stage path
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module sys_stream_bridge #(
    parameter int data_w      = 128,        // Stream width, at least 96
    parameter int stream_id   = 126,        // Reserved system stream
    parameter int queue_depth = 8           // Power of two
) (
    input  logic                            s_clk,
    input  logic                            s_rst,

    // Inbound stream, no back-pressure
    input  logic                            s_in_valid,
    input  logic [sysbus_pkg::id_w-1:0]     s_in_id,
    input  logic [data_w-1:0]               s_in_data,

    // Outbound stream
    input  logic                            s_out_en,
    input  logic [sysbus_pkg::id_w-1:0]     s_out_id,
    output logic [data_w-1:0]               s_out_data,
    output logic                            s_out_ow_dvld,

    // Queue depth poll
    input  logic [sysbus_pkg::id_w-1:0]     s_poll_id,
    output logic [sysbus_pkg::reg_w-1:0]    s_poll_seq,

    input  logic [7:0]                      user_pb_width
);

    // ---------------------------------------------------------------------
    // Register bus
    // ---------------------------------------------------------------------
    logic [sysbus_pkg::addr_w-1:0]  bus_addr;
    logic [sysbus_pkg::reg_w-1:0]   bus_wdata;
    logic                           bus_wr;
    logic                           bus_rd;
    logic                           rd_pending;

    logic [sysbus_pkg::reg_w-1:0]   info_rd_data;
    logic [sysbus_pkg::reg_w-1:0]   counter_rd_data;
    logic [sysbus_pkg::reg_w-1:0]   bus_rdata;

    // Idle blocks drive zero, so OR acts as the read mux
    assign bus_rdata = info_rd_data | counter_rd_data;

    cmd_decoder #(
        .data_w     (data_w),
        .stream_id  (stream_id)
    ) cmd_decoder0 (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .s_in_valid (s_in_valid),
        .s_in_id    (s_in_id),
        .s_in_data  (s_in_data),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .rd_pending (rd_pending)
    );

    card_info_regs card_info0 (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .bus_addr       (bus_addr),
        .bus_rd         (bus_rd),
        .user_pb_width  (user_pb_width),
        .rd_data        (info_rd_data)
    );

    test_counter_regs test_counter0 (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .rd_data    (counter_rd_data)
    );

    resp_queue #(
        .data_w         (data_w),
        .stream_id      (stream_id),
        .queue_depth    (queue_depth)
    ) resp_queue0 (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .rd_pending     (rd_pending),
        .bus_rdata      (bus_rdata),
        .s_out_en       (s_out_en),
        .s_out_id       (s_out_id),
        .s_out_data     (s_out_data),
        .s_out_ow_dvld  (s_out_ow_dvld),
        .s_poll_id      (s_poll_id),
        .s_poll_seq     (s_poll_seq)
    );

endmodule

//--- rtl/sysbus_pkg.sv
// -------------------------------------------------------------------------
// System bus definitions
// Command word layout, register map and card identification constants
// shared by the stream bridge and its register blocks
// -------------------------------------------------------------------------

package sysbus_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------
    localparam int addr_w = 32;             // Register address
    localparam int reg_w  = 32;             // Register data
    localparam int id_w   = 9;              // Stream id

    // ---------------------------------------------------------------------
    // Command word fields
    // ---------------------------------------------------------------------
    // Address in the low word, write data above it, then the write flag.
    // A clear write flag means a read
    localparam int cmd_addr_lsb  = 0;
    localparam int cmd_wdata_lsb = 32;
    localparam int cmd_write_bit = 64;

    // ---------------------------------------------------------------------
    // Register map
    // ---------------------------------------------------------------------
    // Card information block
    localparam logic [addr_w-1:0] addr_magic     = 32'h0000_0000;
    localparam logic [addr_w-1:0] addr_version   = 32'h0000_0004;
    localparam logic [addr_w-1:0] addr_bus_width = 32'h0000_0008;

    // Test counter block
    localparam logic [addr_w-1:0] addr_scratch   = 32'h0000_0100;
    localparam logic [addr_w-1:0] addr_counter   = 32'h0000_0104;

    // ---------------------------------------------------------------------
    // Card identification
    // ---------------------------------------------------------------------
    localparam logic [reg_w-1:0] card_magic   = 32'h5ca1_ab1e;  // Host probes this first
    localparam logic [reg_w-1:0] card_version = 32'h0005_0200;  // Major 5, minor 2

endpackage

//--- rtl/test_counter_regs.sv
// -------------------------------------------------------------------------
// Test counter registers
// Scratch register for bus sanity checks and a counter that advances on
// every read, so the host can spot lost or repeated reads
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module test_counter_regs (
    input  logic                            s_clk,
    input  logic                            s_rst,

    input  logic [sysbus_pkg::addr_w-1:0]   bus_addr,
    input  logic [sysbus_pkg::reg_w-1:0]    bus_wdata,
    input  logic                            bus_wr,
    input  logic                            bus_rd,

    output logic [sysbus_pkg::reg_w-1:0]    rd_data
);

    logic [sysbus_pkg::reg_w-1:0] scratch;
    logic [sysbus_pkg::reg_w-1:0] counter;

    logic hit_scratch;
    logic hit_counter;

    assign hit_scratch = (bus_addr == sysbus_pkg::addr_scratch);
    assign hit_counter = (bus_addr == sysbus_pkg::addr_counter);

    // ---------------------------------------------------------------------
    // Register state
    // ---------------------------------------------------------------------
    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            scratch <= '0;
            counter <= '0;
        end else begin
            if (bus_wr && hit_scratch)
                scratch <= bus_wdata;

            // Host load, or post-increment after a read
            if (bus_wr && hit_counter)
                counter <= bus_wdata;
            else if (bus_rd && hit_counter)
                counter <= counter + 1'b1;      // Wraps at 32 bits
        end
    end

    // ---------------------------------------------------------------------
    // Read data
    // ---------------------------------------------------------------------
    // Counter read returns the value from before the increment
    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            rd_data <= '0;
        end else if (bus_rd && hit_scratch) begin
            rd_data <= scratch;
        end else if (bus_rd && hit_counter) begin
            rd_data <= counter;
        end else begin
            rd_data <= '0;                      // Quiet for the OR at the top
        end
    end

endmodule

//--- sim/tb_sys_stream_bridge.sv
// -------------------------------------------------------------------------
// System stream bridge testbench
// Sends register commands on the inbound stream, polls the response
// queue and compares outbound data with a register map model
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_sys_stream_bridge;

    localparam int data_w      = 128;
    localparam int stream_id   = 126;
    localparam int queue_depth = 8;
    localparam int id_w        = sysbus_pkg::id_w;

    localparam int n_scratch     = 6;
    localparam int n_count_reads = 5;
    localparam int n_foreign     = 4;
    localparam int n_unmapped    = 6;
    localparam int n_cmds        = 3 + 2 * n_scratch + 2 * (1 + n_count_reads)
                                   + (2 + n_foreign) + n_unmapped + queue_depth;
    localparam int cycle_limit   = 40 * n_cmds + 200;

    localparam logic [id_w-1:0] own_id   = stream_id[id_w-1:0];
    localparam logic [id_w-1:0] idle_id  = '0;
    localparam logic [7:0]      pb_width = 8'd64;

    logic                                s_clk;
    logic                                s_rst;
    logic                                s_in_valid;
    logic [id_w-1:0]                     s_in_id;
    logic [data_w-1:0]                   s_in_data;
    logic                                s_out_en;
    logic [id_w-1:0]                     s_out_id;
    logic [data_w-1:0]                   s_out_data;
    logic                                s_out_ow_dvld;
    logic [id_w-1:0]                     s_poll_id;
    logic [sysbus_pkg::reg_w-1:0]        s_poll_seq;
    logic [7:0]                          user_pb_width;

    logic [sysbus_pkg::reg_w-1:0] exp_q [$];    // Expected read results in issue order
    logic [sysbus_pkg::reg_w-1:0] ref_scratch;
    logic [sysbus_pkg::reg_w-1:0] ref_counter;
    int                           model_count;  // Entries the queue should hold
    int                           cycle_count;
    logic [31:0]                  rng_state;

    sys_stream_bridge #(
        .data_w         (data_w),
        .stream_id      (stream_id),
        .queue_depth    (queue_depth)
    ) dut0 (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .s_in_valid     (s_in_valid),
        .s_in_id        (s_in_id),
        .s_in_data      (s_in_data),
        .s_out_en       (s_out_en),
        .s_out_id       (s_out_id),
        .s_out_data     (s_out_data),
        .s_out_ow_dvld  (s_out_ow_dvld),
        .s_poll_id      (s_poll_id),
        .s_poll_seq     (s_poll_seq),
        .user_pb_width  (user_pb_width)
    );

    initial begin
        s_clk = 1'b0;
        forever #20 s_clk = ~s_clk;
    end

    // -------------------------------------------------------------------------
    // Random source and register map model
    // -------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [id_w-1:0] foreign_id();
        logic [31:0]     r;
        logic [id_w-1:0] id;
        r  = next_rand();
        id = r[id_w-1:0];
        if (id == own_id)
            id = ~id;                               // Never the system stream
        return id;
    endfunction

    // Bit 12 set keeps an address off the register map
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        case (r[2:0])
            3'd0:    return sysbus_pkg::addr_magic;
            3'd1:    return sysbus_pkg::addr_version;
            3'd2:    return sysbus_pkg::addr_bus_width;
            3'd3:    return sysbus_pkg::addr_scratch;
            3'd4:    return sysbus_pkg::addr_counter;
            default: return r | 32'h0000_1000;
        endcase
    endfunction

    function automatic logic [sysbus_pkg::reg_w-1:0] ref_access(
        input logic                          is_write,
        input logic [sysbus_pkg::addr_w-1:0] addr,
        input logic [sysbus_pkg::reg_w-1:0]  wdata
    );
        logic [sysbus_pkg::reg_w-1:0] result;
        result = '0;
        if (is_write) begin
            if (addr == sysbus_pkg::addr_scratch)
                ref_scratch = wdata;
            if (addr == sysbus_pkg::addr_counter)
                ref_counter = wdata;
        end else begin
            case (addr)
                sysbus_pkg::addr_magic:     result = sysbus_pkg::card_magic;
                sysbus_pkg::addr_version:   result = sysbus_pkg::card_version;
                sysbus_pkg::addr_bus_width: result = {24'h0, pb_width};
                sysbus_pkg::addr_scratch:   result = ref_scratch;
                sysbus_pkg::addr_counter: begin
                    result      = ref_counter;      // Post-increment on read
                    ref_counter = ref_counter + 32'd1;
                end
                default:                    result = '0;
            endcase
        end
        return result;
    endfunction

    // -------------------------------------------------------------------------
    // Checks and stimulus
    // -------------------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [data_w-1:0] actual,
                               input logic [data_w-1:0] expected);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
    endtask

    task automatic drain_queue();
        repeat (4) @(posedge s_clk);                // Reads still in flight land first
        while (model_count > 0) begin
            @(posedge s_clk);
            s_out_en <= 1'b1;
            s_out_id <= own_id;
            @(posedge s_clk);
            s_out_en <= 1'b0;
            s_out_id <= idle_id;
            model_count--;
        end
        repeat (2) @(posedge s_clk);
    endtask

    task automatic send_cmd(input logic [id_w-1:0] id, input logic is_write,
                            input logic [31:0] addr, input logic [31:0] wdata);
        logic [data_w-1:0] word;
        logic [31:0]       expected;
        word = '0;
        word[sysbus_pkg::cmd_addr_lsb +: sysbus_pkg::addr_w] = addr;
        word[sysbus_pkg::cmd_wdata_lsb +: sysbus_pkg::reg_w] = wdata;
        word[sysbus_pkg::cmd_write_bit]                      = is_write;
        if (id == own_id && !is_write && model_count >= queue_depth)
            drain_queue();                          // Make room first like a host would
        @(posedge s_clk);
        s_in_valid <= 1'b1;
        s_in_id    <= id;
        s_in_data  <= word;
        @(posedge s_clk);
        s_in_valid <= 1'b0;
        s_in_id    <= idle_id;
        if (id == own_id) begin
            expected = ref_access(is_write, addr, wdata);
            if (!is_write) begin
                exp_q.push_back(expected);
                model_count++;
            end
        end
    endtask

    task automatic poll_check();
        repeat (4) @(posedge s_clk);
        s_poll_id <= own_id;
        @(posedge s_clk);
        s_poll_id <= idle_id;
        @(negedge s_clk);
        check_value("s_poll_seq", data_w'(s_poll_seq), data_w'(model_count));
        @(negedge s_clk);
        check_value("s_poll_seq", data_w'(s_poll_seq), '0);    // Other ids read as zero
    endtask

    // Outbound request that must not pop anything
    task automatic expect_no_pop(input logic [id_w-1:0] id);
        @(posedge s_clk);
        s_out_en <= 1'b1;
        s_out_id <= id;
        @(posedge s_clk);
        s_out_en <= 1'b0;
        s_out_id <= idle_id;
        repeat (2) begin
            @(negedge s_clk);
            check_value("s_out_ow_dvld", data_w'(s_out_ow_dvld), '0);
        end
    endtask

    // Compare process
    initial begin
        logic [31:0] head;
        forever begin
            @(negedge s_clk);
            if (s_out_ow_dvld) begin
                if (exp_q.size() == 0) begin
                    fail_run("Outbound data arrived with no read outstanding");
                end else begin
                    head = exp_q.pop_front();
                    check_value("s_out_data", s_out_data, data_w'(head));
                end
            end
        end
    end

    always @(posedge s_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
    end

    // -------------------------------------------------------------------------
    // Test sequence
    // -------------------------------------------------------------------------
    initial begin
        logic [31:0] value;
        s_rst         = 1'b1;
        s_in_valid    = 1'b0;
        s_in_id       = idle_id;
        s_in_data     = '0;
        s_out_en      = 1'b0;
        s_out_id      = idle_id;
        s_poll_id     = idle_id;
        user_pb_width = pb_width;
        ref_scratch   = '0;
        ref_counter   = '0;
        model_count   = 0;
        cycle_count   = 0;
        rng_state     = 32'had6b15ad;
        repeat (16) @(posedge s_clk);
        s_rst <= 1'b0;
        @(posedge s_clk);

        // Card identification
        send_cmd(own_id, 1'b0, sysbus_pkg::addr_magic, '0);
        send_cmd(own_id, 1'b0, sysbus_pkg::addr_version, '0);
        send_cmd(own_id, 1'b0, sysbus_pkg::addr_bus_width, '0);
        poll_check();
        drain_queue();

        for (int i = 0; i < n_scratch; i++) begin
            send_cmd(own_id, 1'b1, sysbus_pkg::addr_scratch, next_rand());
            send_cmd(own_id, 1'b0, sysbus_pkg::addr_scratch, '0);
        end
        drain_queue();

        // Counter loaded just below the wrap and later with a random value
        send_cmd(own_id, 1'b1, sysbus_pkg::addr_counter, 32'hffff_fffd);
        for (int i = 0; i < n_count_reads; i++)
            send_cmd(own_id, 1'b0, sysbus_pkg::addr_counter, '0);
        send_cmd(own_id, 1'b1, sysbus_pkg::addr_counter, next_rand());
        for (int i = 0; i < n_count_reads; i++)
            send_cmd(own_id, 1'b0, sysbus_pkg::addr_counter, '0);
        drain_queue();

        // Traffic on other streams must be ignored
        send_cmd(own_id, 1'b1, sysbus_pkg::addr_scratch, next_rand());
        poll_check();
        for (int i = 0; i < n_foreign; i++)
            send_cmd(foreign_id(), (i % 2) == 0, sysbus_pkg::addr_scratch, next_rand());
        poll_check();
        send_cmd(own_id, 1'b0, sysbus_pkg::addr_scratch, '0);
        drain_queue();

        for (int i = 0; i < n_unmapped; i++) begin
            value = next_rand();
            send_cmd(own_id, 1'b0, value | 32'h0000_1000, '0);
        end
        drain_queue();

        // Fill the queue before polling and pulling from the wrong stream
        for (int i = 0; i < queue_depth; i++)
            send_cmd(own_id, 1'b0, pick_addr(next_rand()), '0);
        poll_check();
        expect_no_pop(foreign_id());
        poll_check();
        drain_queue();
        poll_check();
        expect_no_pop(own_id);                      // Queue is empty here

        repeat (4) @(posedge s_clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected read results never came back", exp_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- tb.f
rtl/sysbus_pkg.sv
rtl/cmd_decoder.sv
rtl/card_info_regs.sv
rtl/test_counter_regs.sv
rtl/resp_queue.sv
rtl/sys_stream_bridge.sv
sim/tb_sys_stream_bridge.sv
